/* sources.f */
+incdir+bench
common/dwc_pkg.sv
common/wide_beat_if.sv
common/burst_ctrl_if.sv
rtl/wr_burst_fsm.sv
rtl/beat_addr_counter.sv
downsize/master_beat_buffer.sv
downsize/lane_select_stage.sv
rtl/dwc_wr_top.sv
bench/tb_dwc_wr.sv

/* Bender.yml */
package:
  name: dwc_wr

sources:
  - common/dwc_pkg.sv
  - common/wide_beat_if.sv
  - common/burst_ctrl_if.sv
  - rtl/wr_burst_fsm.sv
  - rtl/beat_addr_counter.sv
  - downsize/master_beat_buffer.sv
  - downsize/lane_select_stage.sv
  - rtl/dwc_wr_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_dwc_wr.sv

/* bench/tb_dwc_ref.svh */
/*
 * reference model of the downsizer address rule
 *  - byte address, master word and lane of each narrow beat
 *  - number of master beats a burst uses
 *  - expected slave data and strobes of a beat
 */
`ifndef TB_DWC_REF_SVH
`define TB_DWC_REF_SVH

// byte address of beat k, counted from byte 0 of the first master word
function automatic int beat_byte_addr(int start, int size, int k);
   int nbytes;
   int base;
   nbytes = 1 << size;
   // only the first beat may be unaligned
   base   = start - (start % nbytes);
   if (k == 0)
   begin
      return start;
   end
   return base + k * nbytes;
endfunction

function automatic int beat_word(int start, int size, int k);
   return beat_byte_addr(start, size, k) / STRB_W_IN;
endfunction

// bit 2 of the address picks the 32-bit lane
function automatic int beat_lane(int start, int size, int k);
   return (beat_byte_addr(start, size, k) / STRB_W_OUT) % LANES;
endfunction

// last word index plus one
function automatic int master_beat_count(int start, int size, int len);
   return beat_word(start, size, len) + 1;
endfunction

// {data, strb} the slave port should carry for a beat in this lane
function automatic logic [LANE_REC_W-1:0] lane_record(
   logic [DATA_W_IN-1:0] wdata,
   logic [STRB_W_IN-1:0] wstrb,
   int                   lane
);
   return {wdata[lane*DATA_W_OUT +: DATA_W_OUT],
           wstrb[lane*STRB_W_OUT +: STRB_W_OUT]};
endfunction

`endif

/* bench/tb_dwc_wr.sv */
/*
 * testbench for the write-data downsizer
 *  - clock, reset and reset state check
 *  - directed and random bursts with master gaps and slave stalls
 *  - compare process for every accepted slave beat
 */
`timescale 1ns/1ps

module tb_dwc_wr import dwc_pkg::*; ();

   localparam int SEED       = 79;
   localparam int NUM_BURSTS = 300;
   localparam int TIMEOUT    = 200;

   logic                  ACLK;
   logic                  sysReset;
   logic                  cmd_valid;
   logic                  cmd_ready;
   logic [OFF_W-1:0]      cmd_addr;
   logic [LEN_W-1:0]      cmd_len;
   logic [SIZE_W-1:0]     cmd_size;
   logic                  m_wvalid;
   logic                  m_wready;
   logic [DATA_W_IN-1:0]  m_wdata;
   logic [STRB_W_IN-1:0]  m_wstrb;
   logic                  s_wvalid;
   logic                  s_wready;
   logic [DATA_W_OUT-1:0] s_wdata;
   logic [STRB_W_OUT-1:0] s_wstrb;
   logic                  s_wlast;

   // master words and expected slave beats of the current burst
   logic [DATA_W_IN-1:0]  word_data[$];
   logic [STRB_W_IN-1:0]  word_strb[$];
   logic [LANE_REC_W-1:0] exp_beat[$];

   `include "tb_dwc_ref.svh"

   dwc_wr_top i_dut (.*);

   always
   begin
      #50 ACLK = ~ACLK;
   end

   task automatic stop_run();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
      $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      stop_run();
   endtask

   task automatic report_error(string what);
      $display("error at %0t ns: %s", $time, what);
      stop_run();
   endtask

   task automatic drive_command(int addr, int len, int size);
      int wait_cnt;
      cmd_valid = 1'b1;
      cmd_addr  = addr;
      cmd_len   = len;
      cmd_size  = size;
      wait_cnt  = 0;
      @(posedge ACLK);
      while (!cmd_ready)
      begin
         wait_cnt++;
         if (wait_cnt > TIMEOUT)
         begin
            report_error("command was never accepted");
         end
         @(posedge ACLK);
      end
      @(negedge ACLK);
      cmd_valid = 1'b0;
      // fields are latched now, scramble them
      cmd_addr  = $urandom;
      cmd_len   = $urandom;
      cmd_size  = $urandom_range(MAX_SIZE, 0);
   endtask

   task automatic drive_master(int nwords);
      int wait_cnt;
      for (int w = 0; w < nwords; w++)
      begin
         repeat ($urandom_range(2, 0)) @(negedge ACLK);
         m_wvalid = 1'b1;
         m_wdata  = word_data[w];
         m_wstrb  = word_strb[w];
         wait_cnt = 0;
         @(posedge ACLK);
         while (!m_wready)
         begin
            wait_cnt++;
            if (wait_cnt > TIMEOUT)
            begin
               report_error("master beat was never accepted");
            end
            @(posedge ACLK);
         end
         @(negedge ACLK);
         m_wvalid = 1'b0;
      end
   endtask

   ////////////////////////////////////////////////////
   // compare process for the slave write port
   ////////////////////////////////////////////////////
   task automatic check_slave(int nbeats);
      int                  k;
      int                  idle;
      logic                held;
      logic [LANE_REC_W:0] held_val;
      k    = 0;
      idle = 0;
      held = 1'b0;
      while (k < nbeats)
      begin
         s_wready = ($urandom_range(3, 0) != 0);
         @(posedge ACLK);
         if (held)
         begin
            assert (s_wvalid) else report_error("s_wvalid dropped while stalled");
            assert ({s_wlast, s_wdata, s_wstrb} == held_val)
               else report_mismatch("stalled s_wlast/s_wdata/s_wstrb",
                                    {s_wlast, s_wdata, s_wstrb}, held_val);
         end
         if (s_wvalid && s_wready)
         begin
            assert (s_wdata == exp_beat[k][LANE_REC_W-1 -: DATA_W_OUT])
               else report_mismatch("s_wdata", s_wdata, exp_beat[k][LANE_REC_W-1 -: DATA_W_OUT]);
            assert (s_wstrb == exp_beat[k][STRB_W_OUT-1:0])
               else report_mismatch("s_wstrb", s_wstrb, exp_beat[k][STRB_W_OUT-1:0]);
            assert (s_wlast == (k == nbeats - 1))
               else report_mismatch("s_wlast", s_wlast, (k == nbeats - 1));
            assert (!cmd_ready) else report_error("cmd_ready went high inside a burst");
            k++;
            idle = 0;
         end
         else
         begin
            idle++;
            if (idle > TIMEOUT)
            begin
               report_error("no slave beat arrived before the timeout");
            end
         end
         held     = s_wvalid && !s_wready;
         held_val = {s_wlast, s_wdata, s_wstrb};
         @(negedge ACLK);
      end
      s_wready = 1'b0;
   endtask

   task automatic run_burst(int addr, int len, int size);
      int nwords;
      nwords = master_beat_count(addr, size, len);
      word_data.delete();
      word_strb.delete();
      exp_beat.delete();
      for (int w = 0; w < nwords; w++)
      begin
         word_data.push_back({$urandom, $urandom});
         word_strb.push_back($urandom);
      end
      for (int k = 0; k <= len; k++)
      begin
         exp_beat.push_back(lane_record(word_data[beat_word(addr, size, k)],
                                        word_strb[beat_word(addr, size, k)],
                                        beat_lane(addr, size, k)));
      end
      fork
         drive_command(addr, len, size);
         drive_master(nwords);
         check_slave(len + 1);
      join
      // command port back and the buffer drained
      @(posedge ACLK);
      assert (cmd_ready) else report_error("cmd_ready not back after the last beat");
      assert (m_wready) else report_error("a master beat was left in the buffer");
      @(negedge ACLK);
   endtask

   initial
   begin
      void'($urandom(SEED));
      ACLK        = 1'b0;
      sysReset    = 1'b0;
      cmd_valid   = 1'b0;
      cmd_addr    = '0;
      cmd_len     = '0;
      cmd_size    = '0;
      m_wvalid    = 1'b0;
      m_wdata     = '0;
      m_wstrb     = '0;
      s_wready    = 1'b0;
      repeat (2) @(posedge ACLK);
      @(negedge ACLK);
      sysReset = 1'b1;
      @(posedge ACLK);
      assert (!s_wvalid) else report_mismatch("s_wvalid", s_wvalid, 0);
      assert (!s_wlast) else report_mismatch("s_wlast", s_wlast, 0);
      assert (cmd_ready) else report_mismatch("cmd_ready", cmd_ready, 1);
      assert (m_wready) else report_mismatch("m_wready", m_wready, 1);
      @(negedge ACLK);
      // aligned 4 byte burst, then an unaligned byte burst
      run_burst(0, 7, MAX_SIZE);
      run_burst(5, 9, 0);
      for (int b = 0; b < NUM_BURSTS; b++)
      begin
         run_burst($urandom_range(7, 0), $urandom_range(20, 0), $urandom_range(MAX_SIZE, 0));
      end
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* rtl/dwc_wr_top.sv */
/*
 * dwc_wr_top
 * write-data path of a 64 to 32 bit AXI4 downsizer
 * command port, master write port, slave write port
 * FSM, beat counter, master beat buffer and lane stage
 */
`timescale 1ns/1ps

module dwc_wr_top import dwc_pkg::*; (
   input  logic                  ACLK,
   input  logic                  sysReset,

   // command
   input  logic                  cmd_valid,
   output logic                  cmd_ready,
   input  logic [OFF_W-1:0]      cmd_addr,
   input  logic [LEN_W-1:0]      cmd_len,
   input  logic [SIZE_W-1:0]     cmd_size,

   // master write
   input  logic                  m_wvalid,
   output logic                  m_wready,
   input  logic [DATA_W_IN-1:0]  m_wdata,
   input  logic [STRB_W_IN-1:0]  m_wstrb,

   // slave write
   output logic                  s_wvalid,
   input  logic                  s_wready,
   output logic [DATA_W_OUT-1:0] s_wdata,
   output logic [STRB_W_OUT-1:0] s_wstrb,
   output logic                  s_wlast
);

   wide_beat_if  wbeat ();
   burst_ctrl_if ctrl ();

   wr_burst_fsm i_fsm (
      .ACLK      (ACLK),
      .sysReset  (sysReset),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .ctrl      (ctrl.fsm)
   );

   beat_addr_counter i_counter (
      .ACLK     (ACLK),
      .sysReset (sysReset),
      .cmd_addr (cmd_addr),
      .cmd_len  (cmd_len),
      .cmd_size (cmd_size),
      .ctrl     (ctrl.counter)
   );

   master_beat_buffer i_buffer (
      .ACLK     (ACLK),
      .sysReset (sysReset),
      .m_wvalid (m_wvalid),
      .m_wready (m_wready),
      .m_wdata  (m_wdata),
      .m_wstrb  (m_wstrb),
      .beat_out (wbeat.source)
   );

   lane_select_stage i_stage (
      .ACLK     (ACLK),
      .sysReset (sysReset),
      .beat_in  (wbeat.sink),
      .ctrl     (ctrl.stage),
      .s_wvalid (s_wvalid),
      .s_wready (s_wready),
      .s_wdata  (s_wdata),
      .s_wstrb  (s_wstrb),
      .s_wlast  (s_wlast)
   );

endmodule

/* downsize/lane_select_stage.sv */
/*
 * lane_select_stage
 * picks one 32-bit lane of the buffered beat
 * and holds it in the slave write output register
 */
`timescale 1ns/1ps

module lane_select_stage import dwc_pkg::*; (
   input  logic                  ACLK,
   input  logic                  sysReset,
   wide_beat_if.sink             beat_in,
   burst_ctrl_if.stage           ctrl,
   output logic                  s_wvalid,
   input  logic                  s_wready,
   output logic [DATA_W_OUT-1:0] s_wdata,
   output logic [STRB_W_OUT-1:0] s_wstrb,
   output logic                  s_wlast
);

   logic [LANE_REC_W-1:0] lane_rec;

   assign lane_rec = beat_in.beat.lanes[ctrl.lane];

   assign ctrl.out_free = ~s_wvalid | s_wready;
   assign ctrl.issue    = ctrl.active & beat_in.valid & ctrl.out_free;
   // release the word with its last narrow beat
   assign beat_in.ready = ctrl.issue & ctrl.word_done;

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         s_wvalid <= 1'b0;
         s_wlast  <= 1'b0;
      end
      else if (ctrl.issue)
      begin
         s_wvalid <= 1'b1;
         s_wlast  <= ctrl.last;
      end
      else if (s_wready)
      begin
         s_wvalid <= 1'b0;
         s_wlast  <= 1'b0;
      end
   end

   always_ff @(posedge ACLK)
   begin
      if (ctrl.issue)
      begin
         s_wdata <= lane_rec[LANE_REC_W-1 -: DATA_W_OUT];
         s_wstrb <= lane_rec[STRB_W_OUT-1:0];
      end
   end

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////
   a_hold_on_stall : assert property (
      @(posedge ACLK) disable iff (!sysReset)
      s_wvalid && !s_wready |=>
         s_wvalid && $stable(s_wdata) && $stable(s_wstrb) && $stable(s_wlast)
   );

endmodule

/* downsize/master_beat_buffer.sv */
/*
 * master_beat_buffer
 * single-entry register for 64-bit master write beats
 * data and strobes are packed lane by lane into wide_beat_u
 */
`timescale 1ns/1ps

module master_beat_buffer import dwc_pkg::*; (
   input  logic                 ACLK,
   input  logic                 sysReset,
   input  logic                 m_wvalid,
   output logic                 m_wready,
   input  logic [DATA_W_IN-1:0] m_wdata,
   input  logic [STRB_W_IN-1:0] m_wstrb,
   wide_beat_if.source          beat_out
);

   logic       full_q;
   wide_beat_u beat_q;
   wide_beat_u beat_in;
   logic       m_take;

   // lane l gets data bytes and strobes of that lane
   always_comb
   begin
      for (int l = 0; l < LANES; l++)
      begin
         beat_in.lanes[l] = {m_wdata[l*DATA_W_OUT +: DATA_W_OUT],
                             m_wstrb[l*STRB_W_OUT +: STRB_W_OUT]};
      end
   end

   // empty, or drained by the lane stage this cycle
   assign m_wready = ~full_q | beat_out.ready;
   assign m_take   = m_wvalid & m_wready;

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         full_q <= 1'b0;
      end
      else if (m_take)
      begin
         full_q <= 1'b1;
      end
      else if (beat_out.ready)
      begin
         full_q <= 1'b0;
      end
   end

   always_ff @(posedge ACLK)
   begin
      if (m_take)
      begin
         beat_q.whole <= beat_in.whole;
      end
   end

   assign beat_out.valid = full_q;
   assign beat_out.beat  = beat_q;

endmodule

/* rtl/beat_addr_counter.sv */
/*
 * beat_addr_counter
 * narrow beat count and byte offset of the next beat
 * gives lane, word change and last beat to the lane stage
 */
`timescale 1ns/1ps

module beat_addr_counter import dwc_pkg::*; (
   input  logic              ACLK,
   input  logic              sysReset,
   input  logic [OFF_W-1:0]  cmd_addr,
   input  logic [LEN_W-1:0]  cmd_len,
   input  logic [SIZE_W-1:0] cmd_size,
   burst_ctrl_if.counter     ctrl
);

   logic [LEN_W-1:0]  len_q;
   logic [SIZE_W-1:0] size_q;
   logic [LEN_W-1:0]  cnt_q;
   logic [OFF_W-1:0]  addr_q;

   logic [OFF_W:0]    step;
   logic [OFF_W-1:0]  align_mask;
   logic [OFF_W-1:0]  addr_aligned;
   logic [OFF_W:0]    next_sum;

   // beat 0 keeps the unaligned offset, later beats are size aligned
   assign step         = {{OFF_W{1'b0}}, 1'b1} << size_q;
   assign align_mask   = step[OFF_W-1:0] - 1'b1;
   assign addr_aligned = addr_q & ~align_mask;
   assign next_sum     = {1'b0, addr_aligned} + step;

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         len_q  <= '0;
         size_q <= '0;
         cnt_q  <= '0;
         addr_q <= '0;
      end
      else if (ctrl.start)
      begin
         len_q  <= cmd_len;
         size_q <= cmd_size;
         cnt_q  <= '0;
         addr_q <= cmd_addr;
      end
      else if (ctrl.issue)
      begin
         cnt_q  <= cnt_q + 1'b1;
         // carry out of the offset is the move to the next word
         addr_q <= next_sum[OFF_W-1:0];
      end
   end

   assign ctrl.lane      = addr_q[OFF_W-1 -: LANE_IDX_W];
   assign ctrl.last      = (cnt_q == len_q);
   assign ctrl.word_done = ctrl.last | next_sum[OFF_W];

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////
   a_size_legal : assert property (
      @(posedge ACLK) disable iff (!sysReset)
      ctrl.start |=> size_q <= MAX_SIZE
   );

   a_cnt_in_range : assert property (
      @(posedge ACLK) disable iff (!sysReset)
      ctrl.issue |-> cnt_q <= len_q
   );

endmodule

/* rtl/wr_burst_fsm.sv */
/*
 * wr_burst_fsm
 * idle/burst FSM, takes one command at a time
 * pulses start, holds active until the last beat is issued,
 * then waits for that beat to leave the slave port
 */
`timescale 1ns/1ps

module wr_burst_fsm import dwc_pkg::*; (
   input  logic       ACLK,
   input  logic       sysReset,
   input  logic       cmd_valid,
   output logic       cmd_ready,
   burst_ctrl_if.fsm  ctrl
);

   logic state_q;
   // last beat issued, still sitting in the output register
   logic tail_q;

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         state_q <= ST_IDLE;
         tail_q  <= 1'b0;
      end
      else if (state_q == ST_IDLE)
      begin
         if (cmd_valid)
         begin
            state_q <= ST_BURST;
            tail_q  <= 1'b0;
         end
      end
      else if (tail_q)
      begin
         // output empty or accepted this cycle
         if (ctrl.out_free)
         begin
            state_q <= ST_IDLE;
            tail_q  <= 1'b0;
         end
      end
      else if (ctrl.issue && ctrl.last)
      begin
         tail_q <= 1'b1;
      end
   end

   assign cmd_ready   = (state_q == ST_IDLE);
   assign ctrl.start  = cmd_valid & cmd_ready;
   assign ctrl.active = (state_q == ST_BURST) & ~tail_q;

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////
   // previous burst fully drained before a new one starts
   a_no_start_in_burst : assert property (
      @(posedge ACLK) disable iff (!sysReset)
      ctrl.start |-> ctrl.out_free
   );

endmodule

/* common/burst_ctrl_if.sv */
/*
 * burst_ctrl_if
 * control between burst FSM, beat counter and lane stage
 * lane, word_done and last describe the next beat to issue
 */
`timescale 1ns/1ps

interface burst_ctrl_if import dwc_pkg::*; ();

   logic                  start;
   logic                  active;
   logic                  issue;
   logic                  out_free;
   logic [LANE_IDX_W-1:0] lane;
   logic                  word_done;
   logic                  last;

   modport fsm (
      output start,
      output active,
      input  issue,
      input  out_free,
      input  last
   );

   modport counter (
      input  start,
      input  issue,
      output lane,
      output word_done,
      output last
   );

   modport stage (
      input  active,
      input  lane,
      input  word_done,
      input  last,
      output issue,
      output out_free
   );

endinterface

/* common/wide_beat_if.sv */
/*
 * wide_beat_if
 * valid/ready link carrying one buffered master beat
 * from the holding register to the lane stage
 */
`timescale 1ns/1ps

interface wide_beat_if import dwc_pkg::*; ();

   logic       valid;
   logic       ready;
   wide_beat_u beat;

   // buffer side
   modport source (
      output valid,
      output beat,
      input  ready
   );

   // lane stage side, ready only on the last narrow beat of the word
   modport sink (
      input  valid,
      input  beat,
      output ready
   );

endinterface

/* common/dwc_pkg.sv */
/*
 * shared definitions for the write-data downsizer
 *  - master and slave data and strobe widths
 *  - lane count, offset, length and size field widths
 *  - burst state encoding
 *  - wide_beat_u, one master beat seen whole or lane by lane
 */
package dwc_pkg;

   //////////////////////////////////////////////////
   // bus widths
   //////////////////////////////////////////////////
   localparam int DATA_W_IN  = 64;
   localparam int DATA_W_OUT = 32;
   localparam int STRB_W_IN  = DATA_W_IN / 8;
   localparam int STRB_W_OUT = DATA_W_OUT / 8;

   // narrow lanes inside one wide word
   localparam int LANES      = DATA_W_IN / DATA_W_OUT;
   localparam int LANE_IDX_W = $clog2(LANES);
   localparam int LANE_REC_W = DATA_W_OUT + STRB_W_OUT;

   //////////////////////////////////////////////////
   // command fields
   //////////////////////////////////////////////////
   localparam int OFF_W    = $clog2(STRB_W_IN);
   localparam int LEN_W    = 8;
   localparam int SIZE_W   = 3;
   // 4 bytes per narrow beat at most
   localparam int MAX_SIZE = $clog2(STRB_W_OUT);

   // burst state
   localparam logic ST_IDLE  = 1'b0;
   localparam logic ST_BURST = 1'b1;

   //////////////////////////////////////////////////
   // buffered master beat
   //////////////////////////////////////////////////
   // each lane record is {data, strb}, lane 0 in the low bits
   typedef union packed {
      logic [DATA_W_IN+STRB_W_IN-1:0]     whole;
      logic [LANES-1:0][LANE_REC_W-1:0]   lanes;
   } wide_beat_u;

endpackage
